// File: hdl/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Integer register and datapath width
`define XLEN 64

// Instruction word width
`define ILEN 32

// Architectural register count
`define NUM_REGS 32

// Depth of the instruction memory request buffer
// The fetcher starts with this many credits
`define IMEM_CREDITS 4

// Entries in the fetcher's instruction queue
`define FETCH_QUEUE_DEPTH 4

// Stack pointer register loaded from the port at reset
`define SP_REG 2

`endif

// File: hdl/core_pkg.sv
`include "core_params.svh"

package core_pkg;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // Decoded controls carried from decode into execute
  typedef struct packed {
    alu_op_e    alu_op;
    logic       use_imm;
    logic       reg_write;
    logic       is_jal;
    logic       is_branch;
    logic       branch_ne;
    logic [4:0] rd;
  } ctrl_t;

  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  addr;
  } imem_req_t;

  typedef struct packed {
    logic              valid;
    logic [`ILEN-1:0]  instr;
  } imem_rsp_t;

  typedef struct packed {
    logic [`ILEN-1:0]  instr;
    logic [`XLEN-1:0]  pc;
  } fetch_pkt_t;

  // ID/EX contents
  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  pc;
    logic [`XLEN-1:0]  op_a;
    logic [`XLEN-1:0]  op_b;
    logic [`XLEN-1:0]  imm;
    ctrl_t             ctrl;
  } issue_t;

  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  target;
  } redirect_t;

  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  pc;
    logic [4:0]        rd;
    logic              write;
    logic [`XLEN-1:0]  value;
  } retire_t;

endpackage

// File: hdl/core_top.sv
`timescale 1ns/1ps
`include "core_params.svh"

module core_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [`XLEN-1:0]     entry,
  input  logic [`XLEN-1:0]     stack_ptr,
  output core_pkg::imem_req_t  imem_req,
  input  logic                 imem_credit,
  input  core_pkg::imem_rsp_t  imem_rsp,
  output core_pkg::retire_t    retire
);

  core_pkg::redirect_t   redirect;
  core_pkg::fetch_pkt_t  head;
  core_pkg::issue_t      issue;
  logic                  head_valid;
  logic                  take;
  logic [4:0]            rs1_addr, rs2_addr;
  logic [`XLEN-1:0]      rs1_data, rs2_data;
  logic                  rs1_busy, rs2_busy;
  logic                  set_busy;
  logic [4:0]            busy_addr;

  instruction_fetcher fetcher (
    .clk         (clk),
    .reset       (reset),
    .entry       (entry),
    .redirect    (redirect),
    .imem_req    (imem_req),
    .imem_credit (imem_credit),
    .imem_rsp    (imem_rsp),
    .head        (head),
    .head_valid  (head_valid),
    .take        (take)
  );

  instruction_decoder decoder (
    .clk        (clk),
    .reset      (reset),
    .head       (head),
    .head_valid (head_valid),
    .take       (take),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .rs1_busy   (rs1_busy),
    .rs2_busy   (rs2_busy),
    .set_busy   (set_busy),
    .busy_addr  (busy_addr),
    .redirect   (redirect),
    .issue      (issue)
  );

  register_file regs (
    .clk       (clk),
    .reset     (reset),
    .stack_ptr (stack_ptr),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rs1_busy  (rs1_busy),
    .rs2_busy  (rs2_busy),
    .set_busy  (set_busy),
    .busy_addr (busy_addr),
    .retire    (retire)
  );

  // Retire register feeds both the register file write and the top port
  instruction_executor executor (
    .clk      (clk),
    .reset    (reset),
    .issue    (issue),
    .redirect (redirect),
    .retire   (retire)
  );

endmodule

// File: hdl/instruction_decoder.sv
`timescale 1ns/1ps
`include "core_params.svh"

module instruction_decoder (
  input  logic                  clk,
  input  logic                  reset,
  input  core_pkg::fetch_pkt_t  head,
  input  logic                  head_valid,
  output logic                  take,
  output logic [4:0]            rs1_addr,
  output logic [4:0]            rs2_addr,
  input  logic [`XLEN-1:0]      rs1_data,
  input  logic [`XLEN-1:0]      rs2_data,
  input  logic                  rs1_busy,
  input  logic                  rs2_busy,
  output logic                  set_busy,
  output logic [4:0]            busy_addr,
  input  core_pkg::redirect_t   redirect,
  output core_pkg::issue_t      issue
);

  logic [`ILEN-1:0]    ins;
  core_pkg::opcode_e   opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [4:0]          rd;
  logic [`XLEN-1:0]    imm;
  core_pkg::ctrl_t     ctrl;
  logic                uses_rs1, uses_rs2;
  logic                waw, stall;

  assign ins      = head.instr;
  assign opcode   = core_pkg::opcode_e'(ins[6:0]);
  assign rd       = ins[11:7];
  assign funct3   = ins[14:12];
  assign funct7   = ins[31:25];
  assign rs1_addr = ins[19:15];
  assign rs2_addr = ins[24:20];

  always_comb begin
    ctrl     = '0;
    ctrl.rd  = rd;
    imm      = '0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      core_pkg::OPC_OP: begin
        uses_rs1       = 1'b1;
        uses_rs2       = 1'b1;
        ctrl.reg_write = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_op = funct7[5] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
          3'b010:  ctrl.alu_op = core_pkg::ALU_SLT;
          3'b100:  ctrl.alu_op = core_pkg::ALU_XOR;
          3'b110:  ctrl.alu_op = core_pkg::ALU_OR;
          3'b111:  ctrl.alu_op = core_pkg::ALU_AND;
          default: ctrl.reg_write = 1'b0;
        endcase
        // Only SUB may carry a nonzero funct7
        if ((funct7 != 7'b0000000) && !((funct7 == 7'b0100000) && (funct3 == 3'b000)))
          ctrl.reg_write = 1'b0;
      end
      core_pkg::OPC_OP_IMM: begin
        uses_rs1       = 1'b1;
        imm            = {{(`XLEN - 12){ins[31]}}, ins[31:20]};
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = (funct3 == 3'b000);
      end
      core_pkg::OPC_LUI: begin
        imm            = {{(`XLEN - 32){ins[31]}}, ins[31:12], 12'b0};
        ctrl.use_imm   = 1'b1;
        ctrl.alu_op    = core_pkg::ALU_PASS_B;
        ctrl.reg_write = 1'b1;
      end
      core_pkg::OPC_JAL: begin
        imm            = {{(`XLEN - 21){ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        ctrl.is_jal    = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      core_pkg::OPC_BRANCH: begin
        uses_rs1       = 1'b1;
        uses_rs2       = 1'b1;
        imm            = {{(`XLEN - 13){ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        ctrl.is_branch = (funct3[2:1] == 2'b00);
        ctrl.branch_ne = funct3[0];
      end
      default: ;
    endcase
    // x0 is never a destination
    if (rd == 5'd0) ctrl.reg_write = 1'b0;
  end

  // Same rd as the instruction in execute would let its retire clear our busy bit
  assign waw = issue.valid && issue.ctrl.reg_write && ctrl.reg_write && (issue.ctrl.rd == rd);
  assign stall = (uses_rs1 && rs1_busy) || (uses_rs2 && rs2_busy) || waw;
  assign take = head_valid && !stall && !redirect.valid;
  assign set_busy = take && ctrl.reg_write;
  assign busy_addr = rd;

  always_ff @(posedge clk) begin
    if (reset || redirect.valid) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= take;
    end
    if (take) begin
      issue.pc   <= head.pc;
      issue.op_a <= rs1_data;
      issue.op_b <= rs2_data;
      issue.imm  <= imm;
      issue.ctrl <= ctrl;
    end
  end

endmodule

// File: hdl/instruction_executor.sv
`timescale 1ns/1ps
`include "core_params.svh"

module instruction_executor (
  input  logic                 clk,
  input  logic                 reset,
  input  core_pkg::issue_t     issue,
  output core_pkg::redirect_t  redirect,
  output core_pkg::retire_t    retire
);

  logic [`XLEN-1:0] operand_b;
  logic [`XLEN-1:0] alu_out;
  logic [`XLEN-1:0] link;
  logic [`XLEN-1:0] result;
  logic             equal;
  logic             taken;

  assign operand_b = issue.ctrl.use_imm ? issue.imm : issue.op_b;

  always_comb begin
    case (issue.ctrl.alu_op)
      core_pkg::ALU_ADD:    alu_out = issue.op_a + operand_b;
      core_pkg::ALU_SUB:    alu_out = issue.op_a - operand_b;
      core_pkg::ALU_AND:    alu_out = issue.op_a & operand_b;
      core_pkg::ALU_OR:     alu_out = issue.op_a | operand_b;
      core_pkg::ALU_XOR:    alu_out = issue.op_a ^ operand_b;
      core_pkg::ALU_SLT: begin
        alu_out = {{(`XLEN - 1){1'b0}}, ($signed(issue.op_a) < $signed(operand_b))};
      end
      core_pkg::ALU_PASS_B: alu_out = operand_b;
      default:              alu_out = '0;
    endcase
  end

  // JAL links the next sequential pc
  assign link   = issue.pc + `XLEN'(4);
  assign result = issue.ctrl.is_jal ? link : alu_out;

  // BEQ and BNE share one comparator
  assign equal = (issue.op_a == issue.op_b);
  assign taken = issue.valid &&
                 (issue.ctrl.is_jal || (issue.ctrl.is_branch && (equal ^ issue.ctrl.branch_ne)));

  assign redirect = '{valid: taken, target: issue.pc + issue.imm};

  always_ff @(posedge clk) begin
    if (reset) begin
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= issue.valid;
    end
    retire.pc    <= issue.pc;
    retire.rd    <= issue.ctrl.rd;
    retire.write <= issue.ctrl.reg_write;
    retire.value <= result;
  end

endmodule

// File: hdl/instruction_fetcher.sv
`timescale 1ns/1ps
`include "core_params.svh"

module instruction_fetcher (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`XLEN-1:0]      entry,
  input  core_pkg::redirect_t   redirect,
  output core_pkg::imem_req_t   imem_req,
  input  logic                  imem_credit,
  input  core_pkg::imem_rsp_t   imem_rsp,
  output core_pkg::fetch_pkt_t  head,
  output logic                  head_valid,
  input  logic                  take
);

  localparam int QD = `FETCH_QUEUE_DEPTH;
  localparam int PW = $clog2(QD);
  localparam int CW = $clog2(QD + 1);
  localparam int KW = $clog2(`IMEM_CREDITS + 1);

  logic              started;
  logic [`XLEN-1:0]  pc;
  logic [KW-1:0]     credits;
  logic [CW-1:0]     outstanding;
  logic [CW-1:0]     drop_count;
  logic [CW-1:0]     q_count;
  logic [PW-1:0]     q_rd, q_wr, a_rd, a_wr;
  logic [`ILEN-1:0]  q_instr [QD];
  logic [`XLEN-1:0]  q_pc [QD];
  logic [`XLEN-1:0]  a_pc [QD];
  logic [CW:0]       in_use;
  logic              fire;
  logic              keep_rsp;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    next_ptr = (p == PW'(QD - 1)) ? '0 : p + 1'b1;
  endfunction

  // Queued plus in-flight must leave room for every response
  assign in_use = {1'b0, q_count} + {1'b0, outstanding};
  assign fire = started && (credits != '0) && (in_use < (CW + 1)'(QD)) && !redirect.valid;
  assign keep_rsp = imem_rsp.valid && (drop_count == '0) && !redirect.valid;

  assign imem_req = '{valid: fire, addr: pc};
  assign head = '{instr: q_instr[q_rd], pc: q_pc[q_rd]};
  assign head_valid = (q_count != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      started     <= 1'b0;
      pc          <= entry;
      credits     <= KW'(`IMEM_CREDITS);
      outstanding <= '0;
      drop_count  <= '0;
      q_count     <= '0;
      q_rd        <= '0;
      q_wr        <= '0;
      a_rd        <= '0;
      a_wr        <= '0;
    end else begin
      started     <= 1'b1;
      credits     <= credits - KW'(fire) + KW'(imem_credit);
      outstanding <= outstanding + CW'(fire) - CW'(imem_rsp.valid);
      // Address queue tracks every request, dropped or not
      if (fire) a_wr <= next_ptr(a_wr);
      if (imem_rsp.valid) a_rd <= next_ptr(a_rd);
      if (redirect.valid) begin
        pc         <= redirect.target;
        drop_count <= outstanding - CW'(imem_rsp.valid);
        q_count    <= '0;
        q_rd       <= '0;
        q_wr       <= '0;
      end else begin
        if (fire) pc <= pc + `XLEN'(4);
        if (imem_rsp.valid && (drop_count != '0)) drop_count <= drop_count - 1'b1;
        if (keep_rsp) q_wr <= next_ptr(q_wr);
        if (take) q_rd <= next_ptr(q_rd);
        q_count <= q_count + CW'(keep_rsp) - CW'(take);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) a_pc[a_wr] <= pc;
    if (keep_rsp) begin
      q_instr[q_wr] <= imem_rsp.instr;
      q_pc[q_wr]    <= a_pc[a_rd];
    end
  end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps
`include "core_params.svh"

module register_file (
  input  logic                clk,
  input  logic                reset,
  input  logic [`XLEN-1:0]    stack_ptr,
  input  logic [4:0]          rs1_addr,
  input  logic [4:0]          rs2_addr,
  output logic [`XLEN-1:0]    rs1_data,
  output logic [`XLEN-1:0]    rs2_data,
  output logic                rs1_busy,
  output logic                rs2_busy,
  input  logic                set_busy,
  input  logic [4:0]          busy_addr,
  input  core_pkg::retire_t   retire
);

  logic [`XLEN-1:0]     regs [`NUM_REGS];
  logic [`NUM_REGS-1:0] busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= (i == `SP_REG) ? stack_ptr : '0;
      end
      busy <= '0;
    end else begin
      // Retiring write releases its destination
      if (retire.valid && retire.write && (retire.rd != 5'd0)) begin
        regs[retire.rd] <= retire.value;
        busy[retire.rd] <= 1'b0;
      end
      // A newly issued writer to the same rd keeps it busy
      if (set_busy && (busy_addr != 5'd0)) begin
        busy[busy_addr] <= 1'b1;
      end
    end
  end

  // Reads see the array directly, so a write shows up one cycle later
  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

  assign rs1_busy = busy[rs1_addr];
  assign rs2_busy = busy[rs2_addr];

endmodule

// File: project.f
+incdir+hdl
hdl/core_pkg.sv
hdl/instruction_fetcher.sv
hdl/instruction_decoder.sv
hdl/register_file.sv
hdl/instruction_executor.sv
hdl/core_top.sv
tests/retire_checker.sv
tests/core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f project.f --top-module core_tb -o core_sim || exit 1
out=$(./obj_dir/core_sim)
echo "$out"
echo "$out" | grep -qx "Simulation finished: PASS" && exit 0 || exit 1

// File: tests/core_tb.sv
`timescale 1ns/1ps
`include "core_params.svh"

module core_tb;

  localparam int PROG_WORDS = 64;
  localparam logic [`XLEN-1:0] ENTRY_PC = 64'h0000_0000_8000_1000;
  localparam logic [`XLEN-1:0] STACK_TOP = 64'h0000_0000_8010_0000;
  localparam logic [15:0] LFSR_SEED = 16'd23935;
  localparam int RUN_TIMEOUT = 20000;

  logic                 clk;
  logic                 reset;
  logic [`XLEN-1:0]     entry;
  logic [`XLEN-1:0]     stack_ptr;
  core_pkg::imem_req_t  imem_req;
  logic                 imem_credit;
  core_pkg::imem_rsp_t  imem_rsp;
  core_pkg::retire_t    retire;

  logic [`ILEN-1:0]     program_image [PROG_WORDS];
  logic [15:0]          lfsr_state;
  int                   retired;
  int                   errors;
  logic                 done;

  // Memory model holds accepted requests, then popped words waiting to be answered
  logic [`XLEN-1:0]     pending_addr [$];
  logic [`ILEN-1:0]     ready_instr [$];
  int                   ready_cycle [$];
  int                   cycle;
  int                   pop_wait;

  core_top uut (
    .clk         (clk),
    .reset       (reset),
    .entry       (entry),
    .stack_ptr   (stack_ptr),
    .imem_req    (imem_req),
    .imem_credit (imem_credit),
    .imem_rsp    (imem_rsp),
    .retire      (retire)
  );

  retire_checker #(.PROG_WORDS(PROG_WORDS)) retire_check (
    .clk           (clk),
    .reset         (reset),
    .entry         (entry),
    .stack_ptr     (stack_ptr),
    .imem_req      (imem_req),
    .imem_credit   (imem_credit),
    .retire        (retire),
    .program_image (program_image),
    .retired       (retired),
    .errors        (errors),
    .done          (done)
  );

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] rtype_word(input logic [2:0] pick, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = 7'b0000000;
    case (pick)
      3'd1: begin
        f3 = 3'b000;
        f7 = 7'b0100000;
      end
      3'd2:       f3 = 3'b111;
      3'd3:       f3 = 3'b110;
      3'd4:       f3 = 3'b100;
      3'd5, 3'd7: f3 = 3'b010;
      default:    f3 = 3'b000;
    endcase
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] branch_word(input logic ne, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // Forward-only control flow so the program always reaches the final self loop
  task automatic build_program();
    int i;
    int off;
    logic [2:0] kind;
    logic [4:0] rd, rs1, rs2;
    logic [31:0] imm;
    // Reads x2 right away to see the stack pointer
    program_image[0] = addi_word(5'd5, 5'd2, 12'd0);
    for (i = 1; i < PROG_WORDS - 1; i++) begin
      kind = 3'(random_bits(3));
      rd   = 5'(random_bits(3));
      rs1  = 5'(random_bits(3));
      rs2  = 5'(random_bits(3));
      imm  = random_bits(20);
      off  = 1 + int'(random_bits(2));
      if (i + off > PROG_WORDS - 1) off = PROG_WORDS - 1 - i;
      case (kind)
        3'd0, 3'd1: program_image[i] = addi_word(rd, rs1, imm[11:0]);
        3'd2:       program_image[i] = {imm[19:0], rd, 7'b0110111};
        3'd3, 3'd4: program_image[i] = rtype_word(3'(random_bits(3)), rd, rs1, rs2);
        3'd5:       program_image[i] = branch_word(1'b0, rs1, rs2, 13'(off * 4));
        3'd6:       program_image[i] = branch_word(1'b1, rs1, rs2, 13'(off * 4));
        default:    program_image[i] = jal_word(rd, 21'(off * 4));
      endcase
    end
    program_image[PROG_WORDS - 1] = jal_word(5'd0, 21'd0);
  endtask

  function automatic int word_index(input logic [`XLEN-1:0] addr);
    logic [`XLEN-1:0] off;
    off = addr - ENTRY_PC;
    return int'((off >> 2) % 64'(PROG_WORDS));
  endfunction

  // One memory cycle accepts, pops with a credit, then answers in order
  task automatic memory_cycle();
    logic [`XLEN-1:0] addr;
    imem_credit = 1'b0;
    imem_rsp    = '0;
    if (imem_req.valid) pending_addr.push_back(imem_req.addr);
    if (pending_addr.size() != 0) begin
      if (pop_wait == 0) begin
        addr = pending_addr.pop_front();
        imem_credit = 1'b1;
        ready_instr.push_back(program_image[word_index(addr)]);
        ready_cycle.push_back(cycle + 1 + int'(random_bits(2)));
        pop_wait = int'(random_bits(2));
      end else begin
        pop_wait--;
      end
    end
    if ((ready_instr.size() != 0) && (ready_cycle[0] <= cycle)) begin
      imem_rsp.valid = 1'b1;
      imem_rsp.instr = ready_instr.pop_front();
      ready_cycle.delete(0);
    end
    cycle++;
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    imem_credit = 1'b0;
    imem_rsp    = '0;
    cycle       = 0;
    pop_wait    = 0;
    forever begin
      @(posedge clk);
      #1;
      memory_cycle();
    end
  end

  initial begin : run_control
    int waited;
    reset      = 1'b1;
    entry      = ENTRY_PC;
    stack_ptr  = STACK_TOP;
    lfsr_state = LFSR_SEED;
    build_program();
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    waited = 0;
    while (!done && (waited < RUN_TIMEOUT)) begin
      @(posedge clk);
      waited++;
    end
    if (!done) $display("Timeout: run did not complete within %0d cycles", RUN_TIMEOUT);
    $display("Retired %0d instructions, %0d errors", retired, errors);
    if (done && (errors == 0)) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: tests/retire_checker.sv
`timescale 1ns/1ps
`include "core_params.svh"

module retire_checker #(
  parameter int PROG_WORDS    = 64,
  parameter int RETIRE_TARGET = 300,
  parameter int IDLE_LIMIT    = 200
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [`XLEN-1:0]     entry,
  input  logic [`XLEN-1:0]     stack_ptr,
  input  core_pkg::imem_req_t  imem_req,
  input  logic                 imem_credit,
  input  core_pkg::retire_t    retire,
  input  logic [`ILEN-1:0]     program_image [PROG_WORDS],
  output int                   retired,
  output int                   errors,
  output logic                 done
);

  logic [`XLEN-1:0]   model_regs [`NUM_REGS];
  logic [`XLEN-1:0]   model_pc;
  core_pkg::retire_t  expected;
  int                 mismatch_count = 0;
  int                 retire_count = 0;
  logic               finished = 1'b0;
  int                 in_flight = 0;
  int                 idle_cycles = 0;

  assign retired = retire_count;
  assign errors  = mismatch_count;
  assign done    = finished;

  // One architectural step of the model hart
  function automatic core_pkg::retire_t isa_step();
    logic [`ILEN-1:0]  ins;
    logic [`XLEN-1:0]  a, b, off, next_pc;
    core_pkg::retire_t r;
    off     = model_pc - entry;
    ins     = program_image[int'((off >> 2) % 64'(PROG_WORDS))];
    a       = model_regs[ins[19:15]];
    b       = model_regs[ins[24:20]];
    next_pc = model_pc + 64'd4;
    r       = '0;
    r.valid = 1'b1;
    r.pc    = model_pc;
    r.rd    = ins[11:7];
    case (ins[6:0])
      7'b0010011: begin
        r.write = (ins[14:12] == 3'b000);
        r.value = a + {{52{ins[31]}}, ins[31:20]};
      end
      7'b0110011: begin
        r.write = 1'b1;
        case ({ins[31:25], ins[14:12]})
          10'b0000000_000: r.value = a + b;
          10'b0100000_000: r.value = a - b;
          10'b0000000_111: r.value = a & b;
          10'b0000000_110: r.value = a | b;
          10'b0000000_100: r.value = a ^ b;
          10'b0000000_010: r.value = {63'd0, $signed(a) < $signed(b)};
          default:         r.write = 1'b0;
        endcase
      end
      7'b0110111: begin
        r.write = 1'b1;
        r.value = {{32{ins[31]}}, ins[31:12], 12'd0};
      end
      7'b1101111: begin
        r.write = 1'b1;
        r.value = model_pc + 64'd4;
        next_pc = model_pc + {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'b1100011: begin
        if (((ins[14:12] == 3'b000) && (a == b)) || ((ins[14:12] == 3'b001) && (a != b)))
          next_pc = model_pc + {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      default: ;
    endcase
    if (r.rd == 5'd0) r.write = 1'b0;
    if (r.write) model_regs[r.rd] = r.value;
    model_pc = next_pc;
    return r;
  endfunction

  task automatic report_mismatch(input string what, input logic [`XLEN-1:0] got,
                                 input logic [`XLEN-1:0] want);
    $display("FAIL @%0t: %s got %h expected %h", $time, what, got, want);
    mismatch_count++;
  endtask

  task automatic report_problem(input string what);
    $display("Error at %0t: %s", $time, what);
    mismatch_count++;
  endtask

  // Outputs are sampled on the falling clock edge
  always @(negedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) model_regs[i] = '0;
      model_regs[`SP_REG] = stack_ptr;
      model_pc  = entry;
      in_flight = 0;
      if (imem_req.valid) report_problem("imem_req valid while reset is held");
      if (retire.valid) report_problem("retire valid while reset is held");
    end else if (!finished) begin
      in_flight = in_flight + int'(imem_req.valid) - int'(imem_credit);
      if (in_flight > `IMEM_CREDITS) begin
        report_problem($sformatf("%0d requests outstanding without credit", in_flight));
      end
      if (retire.valid) begin
        expected = isa_step();
        if (retire.pc != expected.pc) report_mismatch("retired pc", retire.pc, expected.pc);
        if (retire.write != expected.write) begin
          report_mismatch($sformatf("write flag at pc %h", expected.pc),
                          64'(retire.write), 64'(expected.write));
        end
        if (retire.rd != expected.rd) begin
          report_mismatch($sformatf("rd at pc %h", expected.pc),
                          64'(retire.rd), 64'(expected.rd));
        end
        if (expected.write && (retire.value != expected.value)) begin
          report_mismatch($sformatf("value at pc %h", expected.pc),
                          retire.value, expected.value);
        end
        retire_count++;
        idle_cycles = 0;
        if (retire_count >= RETIRE_TARGET) finished = 1'b1;
      end else begin
        idle_cycles++;
        if (idle_cycles >= IDLE_LIMIT) begin
          report_problem($sformatf("nothing retired for %0d cycles", IDLE_LIMIT));
          idle_cycles = 0;
        end
      end
    end
  end

endmodule
